//--- list.f
source/gr8Pkg.sv
source/busSync.sv
source/slotDecode.sv
source/addrByte.sv
source/sdramSequencer.sv
source/gr8Ram.sv
tests/gr8Ram_sva.sv
tests/gr8RamChecker.sv
tests/gr8RamTb.sv

//--- source/addrByte.sv
`timescale 1ns/1ps
`default_nettype none

module addrByte import gr8Pkg::*; (
	input  wire logic      C25M,
	input  wire logic      reset,
	input  wire logic      load,
	input  wire dataByte_t writeByte,
	input  wire logic      incIn,
	output dataByte_t      value,
	output logic           carryOut
);

	// A load that drops bit 7 bumps the next byte up
	assign carryOut = load ? (value[7] && !writeByte[7]) : (incIn && value == 8'hFF);

	always_ff @(posedge C25M) begin
		if (reset) begin
			value <= '0;
		end else if (load) begin
			value <= writeByte;
		end else if (incIn) begin
			value <= value + 8'd1;
		end
	end

endmodule

`default_nettype wire

//--- source/busSync.sv
`timescale 1ns/1ps
`default_nettype none

module busSync import gr8Pkg::*; (
	input  wire logic        C25M,
	input  wire logic        reset,
	input  wire logic        phi0,
	input  wire logic [15:0] ra,
	input  wire logic        nWe,
	input  wire logic        nDevSel,
	input  wire logic        nIoSel,
	input  wire logic        nIoStrb,
	output busCycle_t        cycle,
	output cyclePhase_t      phase,
	output logic             cycleStart
);

	logic phi0R1, phi0R2;
	logic [2:0] selR1, selR2; // devSel, ioSel, ioStrb
	slotAddr_t offsetQ;
	logic ioSpaceQ;
	logic writeQ;

	// Two-flop synchronizers
	always_ff @(posedge C25M) begin
		if (reset) begin
			phi0R1 <= 1'b0;
			phi0R2 <= 1'b0;
			selR1 <= 3'b000;
			selR2 <= 3'b000;
		end else begin
			phi0R1 <= phi0;
			phi0R2 <= phi0R1;
			selR1 <= {~nDevSel, ~nIoSel, ~nIoStrb};
			selR2 <= selR1;
		end
	end

	assign cycleStart = (phase == phaseIdle) && phi0R1 && !phi0R2;

	// Phase 1..7 then back to idle
	always_ff @(posedge C25M) begin
		if (reset) begin
			phase <= phaseIdle;
		end else if (cycleStart) begin
			phase <= 3'd1;
		end else if (phase != phaseIdle) begin
			phase <= phase + 3'd1; // 7 wraps to idle
		end
	end

	// Address held for the whole cycle
	always_ff @(posedge C25M) begin
		if (cycleStart) offsetQ <= ra[11:0];
	end

	always_ff @(posedge C25M) begin
		if (reset) begin
			ioSpaceQ <= 1'b0;
			writeQ <= 1'b0;
		end else if (cycleStart) begin
			ioSpaceQ <= ra[15:12] == 4'hC;
			writeQ <= !nWe;
		end
	end

	assign cycle = '{
		offset: offsetQ,
		inIoSpace: ioSpaceQ,
		write: writeQ,
		devSel: selR2[2],
		ioSel: selR2[1],
		ioStrb: selR2[0]
	};

endmodule

`default_nettype wire

//--- source/gr8Pkg.sv
`default_nettype none

package gr8Pkg;

	typedef logic [11:0] slotAddr_t;   // Offset inside the C000 page
	typedef logic [7:0]  dataByte_t;
	typedef logic [12:0] sdRow_t;
	typedef logic [8:0]  sdCol_t;
	typedef logic [1:0]  romBank_t;
	typedef logic [2:0]  cyclePhase_t; // 0 is idle

	localparam cyclePhase_t phaseIdle = 3'd0;
	localparam cyclePhase_t phaseLast = 3'd7;

	// Slinky register indices, offset bits 3:0 with bit 7 set
	localparam logic [3:0] regLow  = 4'h0;
	localparam logic [3:0] regMid  = 4'h1;
	localparam logic [3:0] regHigh = 4'h2;
	localparam logic [3:0] regData = 4'h3;
	localparam logic [3:0] regBank = 4'hF;

	localparam logic [1:0] romSdBank = 2'd2; // SDRAM bank holding the ROM image

	typedef enum logic [2:0] {
		cmdNop,
		cmdActive,
		cmdRead,
		cmdWrite,
		cmdPrecharge,
		cmdRefresh
	} sdramCmd_e;

	typedef struct packed {
		logic      cke;
		logic      nCs;
		logic      nRas;
		logic      nCas;
		logic      nWe;
		logic [1:0] ba;
		sdRow_t    a;
		logic      dqml;
		logic      dqmh;
	} sdramPins_t;

	typedef struct packed {
		slotAddr_t offset;
		logic      inIoSpace; // Address was in Cxxx
		logic      write;
		logic      devSel;
		logic      ioSel;
		logic      ioStrb;
	} busCycle_t;

	typedef struct packed {
		logic romRead;
		logic ramSel;
		logic ramWrite;
	} accessSel_t;

endpackage

`default_nettype wire

//--- source/gr8Ram.sv
`timescale 1ns/1ps
`default_nettype none

module gr8Ram import gr8Pkg::*; #(
	parameter int addrBytes     = 3,
	parameter int refreshPeriod = 128
) (
	input  wire logic        C25M,
	input  wire logic        reset,
	input  wire logic        phi0,
	input  wire logic [15:0] ra,
	input  wire logic        nWe,
	input  wire logic        nDevSel,
	input  wire logic        nIoSel,
	input  wire logic        nIoStrb,
	input  wire dataByte_t   rd,
	output logic             rdDir,
	output logic             cke,
	output logic             nCs,
	output logic             nRas,
	output logic             nCas,
	output logic             nSWe,
	output logic [1:0]       ba,
	output logic [12:0]      sa,
	output logic             dqml,
	output logic             dqmh
);

	busCycle_t cycle;
	cyclePhase_t phase;
	logic cycleStart;
	accessSel_t access;
	logic [addrBytes-1:0] byteLoad;
	dataByte_t writeByte;
	logic incAll;
	romBank_t romBank;
	logic [addrBytes-1:0] incIn, carry;
	logic [addrBytes*8-1:0] slinky;
	sdramPins_t pins;

	busSync i_busSync (
		.C25M(C25M), .reset(reset), .phi0(phi0), .ra(ra), .nWe(nWe),
		.nDevSel(nDevSel), .nIoSel(nIoSel), .nIoStrb(nIoStrb),
		.cycle(cycle), .phase(phase), .cycleStart(cycleStart)
	);

	slotDecode #(.addrBytes(addrBytes)) i_slotDecode (
		.C25M(C25M), .reset(reset), .cycle(cycle), .phase(phase), .rd(rd),
		.phi0(phi0), .nWe(nWe), .nDevSel(nDevSel), .nIoSel(nIoSel), .nIoStrb(nIoStrb),
		.access(access), .byteLoad(byteLoad), .writeByte(writeByte),
		.incAll(incAll), .romBank(romBank), .rdDir(rdDir)
	);

	// Carry ripples upward from the low byte
	assign incIn = {carry[addrBytes-2:0], incAll};

	for (genvar i = 0; i < addrBytes; i++) begin : gSlice
		addrByte i_addrByte (
			.C25M(C25M), .reset(reset), .load(byteLoad[i]), .writeByte(writeByte),
			.incIn(incIn[i]), .value(slinky[i*8 +: 8]), .carryOut(carry[i])
		);
	end

	sdramSequencer #(.addrBytes(addrBytes), .refreshPeriod(refreshPeriod)) i_sdramSequencer (
		.C25M(C25M), .reset(reset), .phase(phase), .cycleStart(cycleStart),
		.access(access), .offset(cycle.offset), .romBank(romBank),
		.slinky(slinky), .pins(pins)
	);

	assign cke = pins.cke;
	assign nCs = pins.nCs;
	assign nRas = pins.nRas;
	assign nCas = pins.nCas;
	assign nSWe = pins.nWe;
	assign ba = pins.ba;
	assign sa = pins.a;
	assign dqml = pins.dqml;
	assign dqmh = pins.dqmh;

endmodule

`default_nettype wire

//--- source/sdramSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sdramSequencer import gr8Pkg::*; #(
	parameter int addrBytes     = 3,
	parameter int refreshPeriod = 128
) (
	input  wire logic        C25M,
	input  wire logic        reset,
	input  wire cyclePhase_t phase,
	input  wire logic        cycleStart,
	input  wire accessSel_t  access,
	input  wire slotAddr_t   offset,
	input  wire romBank_t    romBank,
	input  wire logic [addrBytes*8-1:0] slinky,
	output sdramPins_t       pins
);

	localparam int unsigned refBits = $clog2(refreshPeriod);
	localparam logic [refBits-1:0] refLast = refBits'(refreshPeriod - 1);

	// NOP with the clock running
	localparam sdramPins_t nopPins = '{
		cke: 1'b1, nCs: 1'b0, nRas: 1'b1, nCas: 1'b1, nWe: 1'b1,
		ba: 2'b00, a: '0, dqml: 1'b1, dqmh: 1'b1
	};

	logic [refBits-1:0] refCount;
	logic refReq;
	logic activeOpen; // Row open in this bus cycle
	logic opening;
	logic ramRead;
	sdramCmd_e cmd;
	logic cmdCke;
	sdRow_t row;
	sdCol_t col;
	logic [1:0] bank;
	logic lowByte;
	sdramPins_t nextPins;

	assign opening = access.romRead || access.ramSel;
	assign ramRead = access.ramSel && !access.ramWrite;

	// ROM lives in bank 2, RAM uses the slinky address
	assign row = access.romRead ? {9'd0, romBank, offset[11:10]} : slinky[22:10];
	assign col = access.romRead ? offset[9:1] : slinky[9:1];
	assign bank = access.romRead ? romSdBank : {1'b0, slinky[23]};
	assign lowByte = access.romRead ? offset[0] : slinky[0];

	always_ff @(posedge C25M) begin
		if (reset) begin
			refCount <= '0;
			refReq <= 1'b0;
		end else begin
			refCount <= (refCount == refLast) ? '0 : refCount + 1'b1;
			if (refCount == refLast) refReq <= 1'b1;
			else if (cmd == cmdRefresh) refReq <= 1'b0;
		end
	end

	always_comb begin
		cmd = cmdNop;
		cmdCke = 1'b0;
		case (phase)
			phaseIdle: begin
				if (cycleStart) begin
					cmdCke = 1'b1; // Wake the clock for the activate
				end else if (refReq) begin
					cmdCke = 1'b1;
					if (pins.cke) cmd = cmdRefresh; // Only once cke has been high a clock
				end
			end
			3'd1: begin
				cmdCke = opening;
				if (opening) cmd = cmdActive;
			end
			3'd2: begin
				cmdCke = activeOpen;
				if (activeOpen && (access.romRead || ramRead)) cmd = cmdRead;
			end
			3'd5: begin
				cmdCke = activeOpen;
				if (activeOpen && access.ramWrite) cmd = cmdWrite;
			end
			phaseLast: begin
				cmdCke = activeOpen;
				if (activeOpen) cmd = cmdPrecharge;
			end
			default: cmdCke = activeOpen;
		endcase
	end

	always_ff @(posedge C25M) begin
		if (reset) activeOpen <= 1'b0;
		else if (cmd == cmdActive) activeOpen <= 1'b1;
		else if (phase == phaseLast) activeOpen <= 1'b0;
	end

	// Standard SDRAM truth table
	always_comb begin
		nextPins = nopPins;
		nextPins.cke = cmdCke;
		case (cmd)
			cmdActive: begin
				nextPins.nRas = 1'b0;
				nextPins.ba = bank;
				nextPins.a = row;
			end
			cmdRead, cmdWrite: begin
				nextPins.nCas = 1'b0;
				nextPins.nWe = cmd == cmdRead;
				nextPins.ba = bank;
				nextPins.a = {2'b00, 1'b1, 1'b0, col}; // A10 set, auto-precharge
				nextPins.dqml = lowByte;
				nextPins.dqmh = !lowByte;
			end
			cmdPrecharge: begin
				nextPins.nRas = 1'b0;
				nextPins.nWe = 1'b0;
				nextPins.a = 13'h0400; // All banks
			end
			cmdRefresh: begin
				nextPins.nRas = 1'b0;
				nextPins.nCas = 1'b0;
			end
			default: ;
		endcase
	end

	always_ff @(posedge C25M) begin
		if (reset) pins <= nopPins;
		else pins <= nextPins;
	end

endmodule

`default_nettype wire

//--- source/slotDecode.sv
`timescale 1ns/1ps
`default_nettype none

module slotDecode import gr8Pkg::*; #(
	parameter int addrBytes = 3
) (
	input  wire logic        C25M,
	input  wire logic        reset,
	input  wire busCycle_t   cycle,
	input  wire cyclePhase_t phase,
	input  wire dataByte_t   rd,
	input  wire logic        phi0,
	input  wire logic        nWe,
	input  wire logic        nDevSel,
	input  wire logic        nIoSel,
	input  wire logic        nIoStrb,
	output accessSel_t       access,
	output logic [addrBytes-1:0] byteLoad,
	output dataByte_t        writeByte,
	output logic             incAll,
	output romBank_t         romBank,
	output logic             rdDir
);

	logic regEn; // Register space open
	logic romEn; // Expansion ROM open
	logic endOfCycle;
	logic romRead, regSel, ramSel;
	logic regWrite;

	assign endOfCycle = phase == phaseLast;

	assign romRead = cycle.inIoSpace && cycle.offset[11:8] != 4'h0 && !cycle.write;
	assign regSel = cycle.inIoSpace && cycle.offset[11:8] == 4'h0 && cycle.offset[7];
	assign ramSel = regSel && cycle.offset[3:0] == regData && cycle.devSel && regEn;

	assign access = '{romRead: romRead, ramSel: ramSel, ramWrite: ramSel && cycle.write};

	// Register writes land at the end of the bus cycle
	assign regWrite = endOfCycle && regSel && cycle.devSel && cycle.write;
	assign incAll = endOfCycle && ramSel;

	// Write data, one sample behind the bus
	always_ff @(posedge C25M) begin
		writeByte <= rd;
	end

	always_ff @(posedge C25M) begin
		if (reset) begin
			regEn <= 1'b0;
			romEn <= 1'b0;
		end else if (endOfCycle) begin
			if (cycle.ioStrb && cycle.offset[10:0] == 11'h7FF) begin
				romEn <= 1'b0; // CFFF releases the ROM
			end else if (cycle.ioSel) begin
				romEn <= 1'b1;
				regEn <= 1'b1;
			end
		end
	end

	always_ff @(posedge C25M) begin
		if (reset) begin
			romBank <= '0;
		end else if (regWrite && cycle.offset[3:0] == regBank) begin
			romBank <= writeByte[1:0];
		end
	end

	for (genvar i = 0; i < addrBytes; i++) begin : gLoad
		assign byteLoad[i] = regWrite && regEn && cycle.offset[3:0] == 4'(regLow + i);
	end

	// Low turns the bus transceiver toward the Apple
	assign rdDir = !(phi0 && nWe &&
		((!nDevSel && regEn) || !nIoSel || (!nIoStrb && romEn)));

endmodule

`default_nettype wire

//--- tests/gr8RamChecker.sv
`timescale 1ns/1ps
`default_nettype none

module gr8RamChecker #(
	parameter int refreshPeriod = 128
) (
	input wire logic        C25M,
	input wire logic        reset,
	input wire logic        phi0,
	input wire logic        rdDir,
	input wire logic        cke,
	input wire logic        nCs,
	input wire logic        nRas,
	input wire logic        nCas,
	input wire logic        nSWe,
	input wire logic [1:0]  ba,
	input wire logic [12:0] sa,
	input wire logic        dqml,
	input wire logic        dqmh,
	input wire logic [95:0] expName,
	input wire logic [1:0]  expClass, // 0 none, 1 rom, 2 ram
	input wire logic        expWrite,
	input wire logic [12:0] expRow,
	input wire logic [8:0]  expCol,
	input wire logic [1:0]  expBank,
	input wire logic [1:0]  expDqm,
	input wire logic        expRdDir,
	input wire logic        check,
	input wire logic        finish,
	output int              errors,
	output int              refreshes
);

	logic actSeen, colSeen, colWrite, autoPre, dirLow, inCycle;
	logic ckeLowSeen; // Clock stopped at some point in this line
	logic [12:0] actRow;
	logic [1:0] actBank, colBank, colDqm;
	logic [8:0] colAddr;
	int colCount;
	int clocks;

	always @(posedge C25M) begin
		if (reset) begin
			errors = 0;
			refreshes = 0;
			clocks = 0;
			inCycle = 0;
			actSeen = 0;
			colSeen = 0;
			colCount = 0;
			dirLow = 0;
			ckeLowSeen = 0;
		end else begin
			clocks++;
			if (!nCs && !nRas && nCas && nSWe) begin // Activate
				actSeen = 1;
				actRow = sa;
				actBank = ba;
				inCycle = 1;
			end
			if (!nCs && nRas && !nCas) begin // Read or write
				colSeen = 1;
				colCount++;
				colWrite = !nSWe;
				colAddr = sa[8:0];
				autoPre = sa[10];
				colBank = ba;
				colDqm = {dqmh, dqml};
			end
			if (!nCs && !nRas && !nCas && nSWe) begin
				refreshes++;
				if (inCycle) begin
					$display("%0s: refresh issued inside a bus cycle", expName);
					errors++;
				end
			end
			if (!nCs && !nRas && nCas && !nSWe) inCycle = 0; // Precharge
			if (phi0 && !rdDir) dirLow = 1;
			if (!cke) ckeLowSeen = 1;

			if (check) begin
				if (expClass == 2'd0) begin
					if (actSeen || colSeen) begin
						$display("%0s: unexpected SDRAM command in this cycle", expName);
						errors++;
					end
				end else if (!actSeen) begin
					$display("%0s: no activate seen for the access", expName);
					errors++;
				end else if (!colSeen) begin
					$display("%0s: activate not followed by a read or write", expName);
					errors++;
				end else begin
					if (actRow != expRow) begin
						$display("MISMATCH %0s row: expected %h, actual %h", expName, expRow, actRow);
						errors++;
					end
					if (actBank != expBank || colBank != expBank) begin
						$display("MISMATCH %0s bank: expected %0d, actual %0d/%0d",
							expName, expBank, actBank, colBank);
						errors++;
					end
					if (colAddr != expCol) begin
						$display("MISMATCH %0s col: expected %h, actual %h", expName, expCol, colAddr);
						errors++;
					end
					if (colDqm != expDqm) begin
						$display("MISMATCH %0s dqm: expected %b, actual %b", expName, expDqm, colDqm);
						errors++;
					end
					if (colWrite != expWrite) begin
						$display("MISMATCH %0s write: expected %0d, actual %0d",
							expName, expWrite, colWrite);
						errors++;
					end
					if (!autoPre || colCount != 1) begin
						$display("%0s: column command without auto-precharge or repeated", expName);
						errors++;
					end
				end
				if (dirLow == expRdDir) begin
					$display("MISMATCH %0s rdDir: expected %0d, actual %0d",
						expName, expRdDir, !dirLow);
					errors++;
				end
				if (!ckeLowSeen) begin
					$display("%0s: cke never dropped while the bus was idle", expName);
					errors++;
				end
				actSeen = 0;
				colSeen = 0;
				colCount = 0;
				dirLow = 0;
				ckeLowSeen = 0;
			end

			// One refresh per period, served in the idle gaps
			if (finish && refreshes < clocks / refreshPeriod - 1) begin
				$display("Too few refreshes: %0d in %0d clocks", refreshes, clocks);
				errors++;
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/gr8RamPatterns.txt
# name op strobe addr data class row col bank dqm rdDir (hex, dqm is dqmh dqml)
# op R or W, - for a line with no bus cycle
devOff    R dev  C093 00 none 0000 000 0 0 1
preLoad   W dev  C090 55 none 0000 000 0 0 1
ioOpen    R io   C100 00 rom  0000 080 2 2 0
wLow      W dev  C090 34 none 0000 000 0 0 1
wMid      W dev  C091 12 none 0000 000 0 0 1
wHigh     W dev  C092 81 none 0000 000 0 0 1
ramRd0    R dev  C093 00 ram  0044 11A 1 2 0
ramRd1    R dev  C093 00 ram  0044 11A 1 1 0
wLowFF    W dev  C090 FF none 0000 000 0 0 1
ramRdFF   R dev  C093 00 ram  0044 17F 1 1 0
ramRdWrap R dev  C093 00 ram  0044 180 1 2 0
wLow80    W dev  C090 80 none 0000 000 0 0 1
wLow05    W dev  C090 05 none 0000 000 0 0 1
ramRdCy   R dev  C093 00 ram  0045 002 1 1 0
ramWr     W dev  C093 A5 ram  0045 003 1 2 1
wBank     W dev  C09F 03 none 0000 000 0 0 1
romRd     R strb C834 00 rom  000E 01A 2 2 0
romOff    R strb CFFF 00 rom  000F 1FF 2 1 0
romGone   R strb C834 00 rom  000E 01A 2 2 1
idle0     - none 0000 00 none 0000 000 0 0 1
idle1     - none 0000 00 none 0000 000 0 0 1
idle2     - none 0000 00 none 0000 000 0 0 1
idle3     - none 0000 00 none 0000 000 0 0 1
idle4     - none 0000 00 none 0000 000 0 0 1
idle5     - none 0000 00 none 0000 000 0 0 1
idle6     - none 0000 00 none 0000 000 0 0 1
idle7     - none 0000 00 none 0000 000 0 0 1
ramRdEnd  R dev  C093 00 ram  0045 003 1 1 0

//--- tests/gr8RamTb.sv
`timescale 1ns/1ps
`default_nettype none

module gr8RamTb;

	localparam int refreshPeriod = 128;
	localparam int lineClocks = 16;
	localparam int maxLines = 64;

	logic C25M, reset, phi0, nWe, nDevSel, nIoSel, nIoStrb;
	logic [15:0] ra;
	logic [7:0] rd;
	logic rdDir, cke, nCs, nRas, nCas, nSWe, dqml, dqmh;
	logic [1:0] ba;
	logic [12:0] sa;

	logic [95:0] expName;
	logic [1:0] expClass, expBank, expDqm;
	logic expWrite, expRdDir, check, finish;
	logic [12:0] expRow;
	logic [8:0] expCol;
	int errors, refreshes;

	// Parsed pattern lines
	logic [95:0] pName [maxLines];
	logic [31:0] pOp [maxLines];
	logic [31:0] pStrobe [maxLines];
	logic [15:0] pAddr [maxLines];
	logic [7:0] pData [maxLines];
	logic [31:0] pClass [maxLines];
	logic [12:0] pRow [maxLines];
	logic [8:0] pCol [maxLines];
	logic [1:0] pBank [maxLines], pDqm [maxLines];
	logic pRdDir [maxLines];
	int lineCount;
	logic loaded;

	gr8Ram #(.addrBytes(3), .refreshPeriod(refreshPeriod)) i_gr8Ram (
		.C25M(C25M), .reset(reset), .phi0(phi0), .ra(ra), .nWe(nWe),
		.nDevSel(nDevSel), .nIoSel(nIoSel), .nIoStrb(nIoStrb), .rd(rd),
		.rdDir(rdDir), .cke(cke), .nCs(nCs), .nRas(nRas), .nCas(nCas), .nSWe(nSWe),
		.ba(ba), .sa(sa), .dqml(dqml), .dqmh(dqmh)
	);

	gr8RamChecker #(.refreshPeriod(refreshPeriod)) i_checker (
		.C25M(C25M), .reset(reset), .phi0(phi0), .rdDir(rdDir), .cke(cke), .nCs(nCs),
		.nRas(nRas), .nCas(nCas), .nSWe(nSWe), .ba(ba), .sa(sa), .dqml(dqml), .dqmh(dqmh),
		.expName(expName), .expClass(expClass), .expWrite(expWrite), .expRow(expRow),
		.expCol(expCol), .expBank(expBank), .expDqm(expDqm), .expRdDir(expRdDir),
		.check(check), .finish(finish), .errors(errors), .refreshes(refreshes)
	);

	initial begin
		C25M = 1'b0;
		forever #20 C25M = !C25M;
	end

	// Watchdog sized from the pattern count
	initial begin
		wait (loaded);
		#(lineCount * lineClocks * 40 + 2000);
		$display("Timeout: pattern sequence did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

	task automatic loadPatterns(input int fd);
		string line;
		int n;
		lineCount = 0;
		while (!$feof(fd) && lineCount < maxLines) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%s %s %s %h %h %s %h %h %h %h %h", pName[lineCount],
				pOp[lineCount], pStrobe[lineCount], pAddr[lineCount], pData[lineCount],
				pClass[lineCount], pRow[lineCount], pCol[lineCount], pBank[lineCount],
				pDqm[lineCount], pRdDir[lineCount]);
			if (n == 11 && line[0] != "#") lineCount++;
		end
	endtask

	// One Apple bus cycle, PHI0 high in the second half
	task automatic runLine(input int i);
		@(negedge C25M);
		check <= 1'b0;
		phi0 <= 1'b0;
		{nDevSel, nIoSel, nIoStrb} <= 3'b111;
		ra <= pAddr[i];
		rd <= pData[i];
		nWe <= !(pOp[i] == "W");
		expName <= pName[i];
		expClass <= (pClass[i] == "rom") ? 2'd1 : (pClass[i] == "ram") ? 2'd2 : 2'd0;
		expWrite <= pOp[i] == "W";
		expRow <= pRow[i];
		expCol <= pCol[i];
		expBank <= pBank[i];
		expDqm <= pDqm[i];
		expRdDir <= pRdDir[i];
		repeat (8) @(negedge C25M);
		if (pOp[i] != "-") begin
			phi0 <= 1'b1;
			nDevSel <= !(pStrobe[i] == "dev");
			nIoSel <= !(pStrobe[i] == "io");
			nIoStrb <= !(pStrobe[i] == "strb");
		end
		repeat (7) @(negedge C25M);
		check <= 1'b1;
	endtask

	task automatic runAll;
		int assertFails;
		for (int i = 0; i < lineCount; i++) runLine(i);
		@(negedge C25M);
		check <= 1'b0;
		phi0 <= 1'b0;
		{nDevSel, nIoSel, nIoStrb} <= 3'b111;
		repeat (4) @(negedge C25M);
		finish <= 1'b1;
		@(negedge C25M);
		finish <= 1'b0;
		@(negedge C25M);
		assertFails = i_gr8Ram.i_sdramSequencer.i_gr8RamAssert.failures;
		$display("Lines %0d, refreshes %0d, errors %0d, assertion failures %0d",
			lineCount, refreshes, errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	endtask

	initial begin
		int fd;
		reset = 1'b1;
		phi0 = 1'b0;
		ra = '0;
		rd = '0;
		nWe = 1'b1;
		{nDevSel, nIoSel, nIoStrb} = 3'b111;
		{expName, expClass, expWrite, expRow, expCol} = '0;
		{expBank, expDqm, expRdDir, check, finish} = '0;
		loaded = 1'b0;
		fd = $fopen("tests/gr8RamPatterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file");
			$display("*** FAILED ***");
			$finish;
		end else begin
			loadPatterns(fd);
			$fclose(fd);
			loaded = 1'b1;
			repeat (2) @(negedge C25M);
			reset <= 1'b0;
			runAll();
		end
	end

endmodule

`default_nettype wire

//--- tests/gr8Ram_sva.sv
`timescale 1ns/1ps
`default_nettype none

module gr8RamAssert import gr8Pkg::*; (
	input wire logic        C25M,
	input wire logic        reset,
	input wire cyclePhase_t phase,
	input wire sdramPins_t  pins
);

	logic actPins, colPins, prePins, refPins, anyCmd;
	logic rowOpen; // Activate seen on the pins in this bus cycle
	int failures;

	assign actPins = !pins.nCs && !pins.nRas && pins.nCas && pins.nWe;
	assign colPins = !pins.nCs && pins.nRas && !pins.nCas;
	assign prePins = !pins.nCs && !pins.nRas && pins.nCas && !pins.nWe;
	assign refPins = !pins.nCs && !pins.nRas && !pins.nCas && pins.nWe;
	assign anyCmd = !pins.nCs && (!pins.nRas || !pins.nCas || !pins.nWe);

	initial failures = 0;

	always_ff @(posedge C25M) begin
		if (reset) rowOpen <= 1'b0;
		else if (actPins) rowOpen <= 1'b1;
		else if (prePins || phase == phaseIdle) rowOpen <= 1'b0;
	end

	// The SDRAM samples cke a clock ahead, so both edges need it high
	cmdNeedsCke: assert property (@(posedge C25M) disable iff (reset)
		anyCmd |-> (pins.cke && $past(pins.cke)))
		else begin
			$error("SDRAM command issued with cke low");
			failures++;
		end

	colNeedsActive: assert property (@(posedge C25M) disable iff (reset)
		colPins |-> rowOpen)
		else begin
			$error("Column command without an open row");
			failures++;
		end

	refreshOnlyIdle: assert property (@(posedge C25M) disable iff (reset)
		refPins |-> (phase == phaseIdle))
		else begin
			$error("Refresh issued inside a bus cycle");
			failures++;
		end

endmodule

bind sdramSequencer gr8RamAssert i_gr8RamAssert (
	.C25M(C25M), .reset(reset), .phase(phase), .pins(pins)
);

`default_nettype wire
